/* list.f */
verilog/ddrPkg.sv
verilog/ddrRegs.sv
verilog/ddrInitSeq.sv
verilog/ddrCmdEngine.sv
verilog/ddrDataPath.sv
verilog/ddrTop.sv
verif/tbDdrMemModel.sv
verif/tbDdrTop.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbDdrTop -f list.f -o simDdr &&
./obj_dir/simDdr | tee /dev/stderr | grep -q '^Test passed$' || exit 1

/* verif/tbDdrTop.sv */
`timescale 1ns/1ps

module tbDdrTop import ddrPkg::*; ();
	localparam int seqCycles = 1 + tRP + tMRD + tMRD + tRP + 2 * tRFC + tMRD;
	localparam int worstAccessCycles = 20;
	localparam int worstOpCycles = 80 + tRFC;
	localparam int totalOps = 420;
	localparam longint timeoutCycles = 2 * (tPowerUp + seqCycles + totalOps * worstOpCycles);

	logic clk133_270, starting;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [7:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	logic ras, cas, we, cs, cke, dqOutEnable, dqs, dqsEnable;
	logic [12:0] ddrAddr;
	logic [1:0] ddrBank;
	logic [15:0] dqOut, dqIn;
	logic [31:0] expMem [logic [24:0]];
	logic [24:0] written [$];
	int errors = 0;
	int checks = 0;

	ddrTop i_dut (.*);

	tbDdrMemModel tbModel (.clk(clk133_270), .cke(cke), .cs(cs), .ras(ras), .cas(cas),
		.we(we), .addr(ddrAddr), .bank(ddrBank), .dqOut(dqOut),
		.dqOutEnable(dqOutEnable), .dqs(dqs), .dqsEnable(dqsEnable), .dqIn(dqIn));

	initial begin
		clk133_270 = 1'b0;
		forever #50 clk133_270 = ~clk133_270;
	end

	initial begin
		#(timeoutCycles * 100);
		$display("Timeout: the run did not finish in time");
		$display("Test failed");
		$finish;
	end

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic writeReg(input logic [7:0] a, input logic [31:0] d, output logic [1:0] resp);
		@(posedge clk133_270);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= a;
		wdata   <= d;
		do @(negedge clk133_270); while (!awready);
		@(posedge clk133_270);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clk133_270); while (!bvalid);
		resp = bresp;
	endtask

	task automatic readReg(input logic [7:0] a, output logic [31:0] d, output logic [1:0] resp);
		@(posedge clk133_270);
		arvalid <= 1'b1;
		araddr  <= a;
		do @(negedge clk133_270); while (!arready);
		@(posedge clk133_270);
		arvalid <= 1'b0;
		do @(negedge clk133_270); while (!rvalid);
		d = rdata;
		resp = rresp;
	endtask

	task automatic waitIdle();
		logic [31:0] v;
		logic [1:0] r;
		do readReg(regStatus, v, r); while (v[1]);
	endtask

	// Runs one access to completion and checks the word that a read returns.
	task automatic runAccess(input logic [1:0] kind, input logic [24:0] a, input logic [31:0] d);
		logic [1:0] r;
		logic [31:0] v;
		writeReg(regAddr, {7'd0, a}, r);
		writeReg(regWdata, d, r);
		writeReg(regCtrl, {29'd0, kind, 1'b1}, r);
		checkValue(r, respOkay, "ctrl write response");
		waitIdle();
		if (kind == opWrite) begin
			expMem[a] = d;
			written.push_back(a);
		end
		if (kind == opRead) begin
			readReg(regRdata, v, r);
			checkValue(v, expMem.exists(a) ? expMem[a] : 32'h0, "read data");
		end
	endtask

	task automatic loadMode(input logic [14:0] word);
		logic [1:0] r;
		writeReg(regMode, {17'd0, word}, r);
		runAccess(opLoadMode, '0, '0);
	endtask

	function automatic logic [24:0] randomAddr();
		logic [1:0] b;
		logic [12:0] row;
		logic [9:0] col;
		b = 2'($urandom % 4);
		row = 13'(($urandom % 8) * 977);
		col = 10'(($urandom % 16) * 2);
		return {b, row, col};
	endfunction

	function automatic logic [24:0] writtenAddr();
		return written[$urandom % written.size()];
	endfunction

	// Reads revisit written addresses and writes go anywhere.
	task automatic randomAccess();
		if ($urandom % 2)
			runAccess(opRead, writtenAddr(), '0);
		else
			runAccess(opWrite, randomAddr(), $urandom);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		$display("%s: %s", name, (errors == errBefore) ? "ok" : "FAILED");
	endtask

	initial begin
		logic [31:0] v;
		logic [1:0] r;
		logic [24:0] a;
		int e, acts, refs;
		longint t0, cycles;
		void'($urandom(32'h575c6759));
		starting = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = 4'hF;
		bready = 1'b1;
		rready = 1'b1;
		repeat (2) @(posedge clk133_270);
		starting <= 1'b0;

		// ============================================================
		e = errors;
		readReg(regStatus, v, r);
		checkValue(v, 32'h0, "status before start-up");
		writeReg(regCtrl, 32'h1, r);
		checkValue(r, respSlvErr, "ctrl write before start-up");
		do begin
			repeat (100) @(posedge clk133_270);
			readReg(regStatus, v, r);
		end while (!v[0]);
		checkValue(v, 32'h1, "status after start-up");
		checkValue(tbModel.seqLen, 7, "start-up command count");
		checkValue(tbModel.seqCmd[0], cmdPrecharge, "step 0");
		checkValue(tbModel.seqAddr[0][10], 1'b1, "step 0 all banks");
		checkValue(tbModel.seqCmd[1], cmdLoadMode, "step 1");
		checkValue({tbModel.seqBank[1], tbModel.seqAddr[1]}, defaultExtModeWord, "ext mode");
		checkValue(tbModel.seqCmd[2], cmdLoadMode, "step 2");
		checkValue({tbModel.seqBank[2], tbModel.seqAddr[2]}, defaultModeWord, "base mode");
		checkValue(tbModel.seqCmd[3], cmdPrecharge, "step 3");
		checkValue(tbModel.seqAddr[3][10], 1'b1, "step 3 all banks");
		checkValue(tbModel.seqCmd[4], cmdAutoRefresh, "step 4");
		checkValue(tbModel.seqCmd[5], cmdAutoRefresh, "step 5");
		checkValue({tbModel.seqBank[6], tbModel.seqAddr[6], 3'(tbModel.seqCmd[6])},
			{defaultModeWord, cmdLoadMode}, "step 6");
		reportTest("test 1 start-up", e);

		e = errors;
		for (int i = 0; i < 40; i++)
			runAccess(opWrite, randomAddr(), $urandom);
		for (int i = 0; i < 40; i++)
			runAccess(opRead, writtenAddr(), '0);
		reportTest("test 2 random write and read", e);

		// ============================================================
		e = errors;
		readReg(8'h20, v, r);
		checkValue(r, respSlvErr, "unmapped read");
		writeReg(8'h24, 32'h5, r);
		checkValue(r, respSlvErr, "unmapped write");
		acts = tbModel.activateCount;
		a = randomAddr();
		writeReg(regAddr, {7'd0, a}, r);
		writeReg(regCtrl, {29'd0, opRead, 1'b1}, r);
		writeReg(regCtrl, {29'd0, opWrite, 1'b1}, r);
		checkValue(r, respSlvErr, "ctrl write while busy");
		waitIdle();
		checkValue(tbModel.activateCount, acts + 1, "activates for one access");
		reportTest("test 3 error responses", e);

		e = errors;
		loadMode(15'b00_000000_011_0_001);
		checkValue(tbModel.casLat, 3'd3, "latency after base load");
		for (int i = 0; i < 10; i++)
			randomAccess();
		loadMode(15'b01_00000000000_1_0);
		checkValue(tbModel.casLat, 3'd3, "latency after ext load");
		for (int i = 0; i < 6; i++)
			runAccess(opRead, writtenAddr(), '0);
		reportTest("test 4 mode load", e);

		// ============================================================
		e = errors;
		refs = tbModel.refreshCount;
		t0 = $time;
		for (int i = 0; i < 300; i++)
			randomAccess();
		cycles = ($time - t0) / 100;
		checkValue(32'(tbModel.refreshCount - refs >=
			cycles / (tREFI + tRFC + worstAccessCycles)), 32'h1, "refresh count");
		checkValue(tbModel.protocolErrors, 0, "protocol errors");
		reportTest("test 5 long traffic", e);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* verif/tbDdrMemModel.sv */
`timescale 1ns/1ps

module tbDdrMemModel import ddrPkg::*; (
	input  logic        clk,
	input  logic        cke,
	input  logic        cs,
	input  logic        ras,
	input  logic        cas,
	input  logic        we,
	input  logic [12:0] addr,
	input  logic [1:0]  bank,
	input  logic [15:0] dqOut,
	input  logic        dqOutEnable,
	input  logic        dqs,
	input  logic        dqsEnable,
	output logic [15:0] dqIn
);
	logic [15:0] mem [logic [24:0]];
	logic [12:0] openRow [4];
	logic        rowOpen [4];
	logic [2:0]  seqCmd [8];
	logic [12:0] seqAddr [8];
	logic [1:0]  seqBank [8];
	logic [2:0]  casLat;
	int          seqLen;
	int          refreshCount;
	int          activateCount;
	int          protocolErrors;
	int          wrPhase;
	logic [24:0] wrKey;
	int          rdCount;
	logic        rdHigh;
	logic [24:0] rdKey;

	function automatic logic [15:0] beatAt(input logic [24:0] key);
		return mem.exists(key) ? mem[key] : 16'h0000;
	endfunction

	initial begin
		for (int i = 0; i < 4; i++) begin
			rowOpen[i] = 1'b0;
			openRow[i] = '0;
		end
		casLat = 3'd0;
		seqLen = 0;
		refreshCount = 0;
		activateCount = 0;
		protocolErrors = 0;
		wrPhase = 0;
		rdCount = 0;
		rdHigh = 1'b0;
		dqIn = '0;
	end

	// Pins are decoded at the falling edge halfway between DUT updates.
	always @(negedge clk) begin
		logic [2:0]  cmd;
		logic        ready;
		logic [24:0] key;
		cmd = {ras, cas, we};
		if (wrPhase != 0) begin
			// DQS is high with the first beat and low with the second.
			if (!dqOutEnable || !dqsEnable || dqs != (wrPhase == 1)) begin
				$display("Protocol error at %0t: write beat with bad data drive or DQS",
					$time);
				protocolErrors++;
			end
			mem[wrKey + 25'(wrPhase - 1)] = dqOut;
			wrPhase = (wrPhase == 2) ? 0 : wrPhase + 1;
		end
		if (rdHigh) begin
			dqIn <= beatAt(rdKey + 25'd1);
			rdHigh = 1'b0;
		end
		if (rdCount > 0) begin
			rdCount--;
			if (rdCount == 0) begin
				dqIn <= beatAt(rdKey);
				rdHigh = 1'b1;
			end
		end
		if (cke && !cs && cmd != cmdNoop) begin
			ready = (seqLen >= 7);
			if (!ready) begin
				seqCmd[seqLen]  = cmd;
				seqAddr[seqLen] = addr;
				seqBank[seqLen] = bank;
				seqLen++;
			end
			key = {bank, openRow[bank], addr[9:0]};
			case (cmd)
				cmdLoadMode: begin
					if (bank == 2'd0)
						casLat = addr[6:4];
				end
				cmdAutoRefresh: begin
					if (ready)
						refreshCount++;
				end
				cmdPrecharge: begin
					for (int i = 0; i < 4; i++) begin
						if (addr[10] || bank == 2'(i))
							rowOpen[i] = 1'b0;
					end
				end
				cmdActivate: begin
					if (!ready) begin
						$display("Protocol error at %0t: activate before start-up", $time);
						protocolErrors++;
					end
					activateCount++;
					rowOpen[bank] = 1'b1;
					openRow[bank] = addr;
				end
				default: begin
					if (!ready || !rowOpen[bank]) begin
						$display("Protocol error at %0t: column command with no open row",
							$time);
						protocolErrors++;
					end
					if (cmd == cmdWrite) begin
						wrPhase = 1;
						wrKey   = key;
					end else begin
						rdCount = casLat;
						rdKey   = key;
					end
				end
			endcase
		end
	end

endmodule

/* verilog/ddrTop.sv */
`timescale 1ns/1ps

module ddrTop import ddrPkg::*; (
	input  logic        clk133_270,
	input  logic        starting,
	input  logic        awvalid,
	output logic        awready,
	input  logic [7:0]  awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [7:0]  araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        ras,
	output logic        cas,
	output logic        we,
	output logic        cs,
	output logic        cke,
	output logic [12:0] ddrAddr,
	output logic [1:0]  ddrBank,
	output logic [15:0] dqOut,
	output logic        dqOutEnable,
	input  logic [15:0] dqIn,
	output logic        dqs,
	output logic        dqsEnable
);
	// Register block to engine.
	logic        opStart;
	logic [1:0]  op;
	logic [24:0] accessAddr;
	logic [31:0] writeWord;
	ddrModeWord  modeWord;
	logic        busy;
	logic [31:0] readWord;
	logic        readDone;

	// Start-up sequencer to engine.
	logic [2:0]  initCommand;
	logic [12:0] initAddr;
	logic [1:0]  initBank;
	logic        initCke;
	logic        initDone;

	// Engine to data path.
	logic        writeStart;
	logic [31:0] writeData;
	logic        readStart;
	logic [2:0]  casLatency;
	logic [31:0] capturedWord;
	logic        captureDone;

	ddrRegs      iRegs      (.*);
	ddrInitSeq   iInitSeq   (.*);
	ddrCmdEngine iCmdEngine (.*);
	ddrDataPath  iDataPath  (.*);

endmodule

/* verilog/ddrDataPath.sv */
`timescale 1ns/1ps

module ddrDataPath (
	input  logic        clk133_270,
	input  logic        starting,
	input  logic        writeStart,
	input  logic [31:0] writeData,
	input  logic        readStart,
	input  logic [2:0]  casLatency,
	output logic [15:0] dqOut,
	output logic        dqOutEnable,
	output logic        dqs,
	output logic        dqsEnable,
	input  logic [15:0] dqIn,
	output logic [31:0] capturedWord,
	output logic        captureDone
);
	logic        secondBeat;
	logic        postamble;
	logic [2:0]  readCount;
	logic        captureHigh;
	logic [15:0] lowBeat;

	// ============================================================
	// Write beats go out lower half first with DQS held one cycle past the data.
	// ============================================================
	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			dqOutEnable <= 1'b0;
			dqsEnable   <= 1'b0;
			dqs         <= 1'b0;
			secondBeat  <= 1'b0;
			postamble   <= 1'b0;
		end else begin
			secondBeat <= writeStart;
			postamble  <= secondBeat;
			if (writeStart) begin
				dqOutEnable <= 1'b1;
				dqsEnable   <= 1'b1;
				dqs         <= 1'b1;
			end else if (secondBeat) begin
				dqs <= 1'b0;
			end else if (postamble) begin
				dqOutEnable <= 1'b0;
			end else begin
				dqsEnable <= 1'b0;
			end
		end
	end

	// Read capture counts CAS latency from the read command.
	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			readCount   <= '0;
			captureHigh <= 1'b0;
			captureDone <= 1'b0;
		end else begin
			if (readStart)
				readCount <= casLatency;
			else if (readCount != 0)
				readCount <= readCount - 3'd1;
			captureHigh <= (readCount == 3'd1);
			captureDone <= captureHigh;
		end
	end

	always_ff @(posedge clk133_270) begin
		if (writeStart)
			dqOut <= writeData[15:0];
		else if (secondBeat)
			dqOut <= writeData[31:16];
		if (readCount == 3'd1)
			lowBeat <= dqIn;
		if (captureHigh)
			capturedWord <= {dqIn, lowBeat};
	end

	// The engine must never overlap a write burst with read data.
	assert property (@(posedge clk133_270) disable iff (starting)
		(readCount == 3'd1 || captureHigh) |-> !dqOutEnable);

endmodule

/* verilog/ddrCmdEngine.sv */
`timescale 1ns/1ps

module ddrCmdEngine import ddrPkg::*; (
	input  logic        clk133_270,
	input  logic        starting,
	input  logic        opStart,
	input  logic [1:0]  op,
	input  logic [24:0] accessAddr,
	input  logic [31:0] writeWord,
	input  ddrModeWord  modeWord,
	output logic        busy,
	output logic [31:0] readWord,
	output logic        readDone,
	input  logic [2:0]  initCommand,
	input  logic [12:0] initAddr,
	input  logic [1:0]  initBank,
	input  logic        initCke,
	input  logic        initDone,
	output logic        ras,
	output logic        cas,
	output logic        we,
	output logic        cs,
	output logic        cke,
	output logic [12:0] ddrAddr,
	output logic [1:0]  ddrBank,
	output logic        writeStart,
	output logic [31:0] writeData,
	output logic        readStart,
	output logic [2:0]  casLatency,
	input  logic [31:0] capturedWord,
	input  logic        captureDone
);
	typedef enum logic [2:0] {
		stIdle, stActivate, stColumn, stRecovery, stPrecharge, stWait
	} engineState;

	engineState  state;
	logic [3:0]  waitCount;
	logic [2:0]  command;
	logic [12:0] cmdAddr;
	logic [1:0]  cmdBank;
	logic        opPending;
	logic        inRefresh;
	logic        refreshPending;
	logic [10:0] refreshCount;
	logic [1:0]  curOp;
	logic [24:0] curAddr;
	ddrModeWord  curMode;
	logic [1:0]  useOp;
	logic [24:0] useAddr;
	ddrModeWord  useMode;
	logic [2:0]  busCommand;

	// An access accepted straight from idle takes the request from the registers.
	assign useOp   = opStart ? op : curOp;
	assign useAddr = opStart ? accessAddr : curAddr;
	assign useMode = opStart ? modeWord : curMode;

	// The sequencer owns the pins until start-up completes.
	assign {ras, cas, we} = initDone ? command : initCommand;
	assign ddrAddr        = initDone ? cmdAddr : initAddr;
	assign ddrBank        = initDone ? cmdBank : initBank;
	assign cke            = initCke;
	assign cs             = ~initCke;
	assign busCommand     = {ras, cas, we};

	always_ff @(posedge clk133_270) begin
		if (opStart) begin
			curOp     <= op;
			curAddr   <= accessAddr;
			curMode   <= modeWord;
			writeData <= writeWord;
		end
		if (captureDone)
			readWord <= capturedWord;
	end

	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			state          <= stIdle;
			waitCount      <= '0;
			command        <= cmdNoop;
			cmdAddr        <= '0;
			cmdBank        <= '0;
			busy           <= 1'b0;
			readDone       <= 1'b0;
			opPending      <= 1'b0;
			inRefresh      <= 1'b0;
			refreshPending <= 1'b0;
			refreshCount   <= '0;
			writeStart     <= 1'b0;
			readStart      <= 1'b0;
			casLatency     <= defaultModeWord.base.casLatency;
		end else begin
			command    <= cmdNoop;
			writeStart <= 1'b0;
			readStart  <= 1'b0;
			readDone   <= captureDone;
			if (opStart) begin
				busy      <= 1'b1;
				opPending <= 1'b1;
			end
			if (waitCount != 0)
				waitCount <= waitCount - 4'd1;
			case (state)
				stIdle: begin
					if (refreshPending) begin
						command        <= cmdAutoRefresh;
						refreshPending <= 1'b0;
						inRefresh      <= 1'b1;
						waitCount      <= 4'(tRFC - 1);
						state          <= stWait;
					end else if (opPending || opStart) begin
						opPending <= 1'b0;
						if (useOp == opLoadMode) begin
							command   <= cmdLoadMode;
							cmdAddr   <= useMode[12:0];
							cmdBank   <= useMode[14:13];
							waitCount <= 4'(tMRD - 1);
							state     <= stWait;
							if (useMode.base.bank == 2'd0)
								casLatency <= useMode.base.casLatency;
						end else begin
							command   <= cmdActivate;
							cmdAddr   <= useAddr[22:10];
							cmdBank   <= useAddr[24:23];
							waitCount <= 4'(tRCD - 1);
							state     <= stActivate;
						end
					end
				end
				stActivate: begin
					if (waitCount == 0) begin
						// A10 stays low so the column command has no auto precharge.
						cmdAddr <= {3'b000, curAddr[9:0]};
						if (curOp == opWrite) begin
							command    <= cmdWrite;
							writeStart <= 1'b1;
							waitCount  <= 4'(tWR - 2);
							state      <= stRecovery;
						end else begin
							command   <= cmdRead;
							readStart <= 1'b1;
							state     <= stColumn;
						end
					end
				end
				stColumn: begin
					if (captureDone)
						state <= stPrecharge;
				end
				// The count stops one short because stPrecharge adds the last cycle of tWR.
				stRecovery: begin
					if (waitCount == 0)
						state <= stPrecharge;
				end
				stPrecharge: begin
					command   <= cmdPrecharge;
					cmdAddr   <= '0;
					waitCount <= 4'(tRP - 1);
					state     <= stWait;
				end
				default: begin
					if (waitCount == 0) begin
						state <= stIdle;
						if (inRefresh)
							inRefresh <= 1'b0;
						else
							busy <= 1'b0;
					end
				end
			endcase
			if (initDone) begin
				if (refreshCount == 11'(tREFI - 1)) begin
					refreshCount   <= '0;
					refreshPending <= 1'b1;
				end else
					refreshCount <= refreshCount + 11'd1;
			end
		end
	end

	assert property (@(posedge clk133_270) disable iff (starting)
		busCommand == cmdActivate |=>
		(busCommand != cmdWrite && busCommand != cmdRead) [*tRCD-1]);

	assert property (@(posedge clk133_270) disable iff (starting)
		busCommand == cmdAutoRefresh |=> busCommand == cmdNoop [*tRFC-1]);

endmodule

/* verilog/ddrInitSeq.sv */
`timescale 1ns/1ps

module ddrInitSeq import ddrPkg::*; (
	input  logic        clk133_270,
	input  logic        starting,
	output logic [2:0]  initCommand,
	output logic [12:0] initAddr,
	output logic [1:0]  initBank,
	output logic        initCke,
	output logic        initDone
);
	logic [14:0] powerCount;
	logic [2:0]  stepIdx;
	logic [3:0]  stepCount;
	logic [2:0]  stepCommand;
	logic [14:0] stepWord;
	logic [3:0]  stepDelay;

	// ============================================================
	// Start-up table of command, bank and address and the gap after it.
	// ============================================================
	always_comb begin
		stepCommand = cmdNoop;
		stepWord    = '0;
		stepDelay   = 4'd1;
		case (stepIdx)
			3'd0, 3'd3: begin
				// A10 high selects all banks.
				stepCommand = cmdPrecharge;
				stepWord    = 15'h0400;
				stepDelay   = 4'(tRP);
			end
			3'd1: begin
				stepCommand = cmdLoadMode;
				stepWord    = defaultExtModeWord;
				stepDelay   = 4'(tMRD);
			end
			3'd2, 3'd6: begin
				stepCommand = cmdLoadMode;
				stepWord    = defaultModeWord;
				stepDelay   = 4'(tMRD);
			end
			3'd4, 3'd5: begin
				stepCommand = cmdAutoRefresh;
				stepDelay   = 4'(tRFC);
			end
			default: ;
		endcase
	end

	// The cycle in which cke rises is the noop that opens the sequence.
	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			powerCount  <= '0;
			stepIdx     <= '0;
			stepCount   <= '0;
			initCommand <= cmdNoop;
			initAddr    <= '0;
			initBank    <= '0;
			initCke     <= 1'b0;
			initDone    <= 1'b0;
		end else if (!initCke) begin
			powerCount <= powerCount + 15'd1;
			if (powerCount == 15'(tPowerUp - 1))
				initCke <= 1'b1;
		end else if (!initDone) begin
			initCommand <= cmdNoop;
			if (stepCount != 0) begin
				stepCount <= stepCount - 4'd1;
			end else if (stepIdx == 3'd7) begin
				initDone <= 1'b1;
			end else begin
				initCommand <= stepCommand;
				initAddr    <= stepWord[12:0];
				initBank    <= stepWord[14:13];
				stepCount   <= stepDelay - 4'd1;
				stepIdx     <= stepIdx + 3'd1;
			end
		end
	end

	assert property (@(posedge clk133_270) disable iff (starting)
		initDone |=> initDone);

endmodule

/* verilog/ddrRegs.sv */
`timescale 1ns/1ps

module ddrRegs import ddrPkg::*; (
	input  logic        clk133_270,
	input  logic        starting,
	input  logic        awvalid,
	output logic        awready,
	input  logic [7:0]  awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [7:0]  araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        opStart,
	output logic [1:0]  op,
	output logic [24:0] accessAddr,
	output logic [31:0] writeWord,
	output ddrModeWord  modeWord,
	input  logic        busy,
	input  logic        initDone,
	input  logic [31:0] readWord,
	input  logic        readDone
);
	logic [31:0] readHold;
	logic [31:0] readData;
	logic        readErr;
	logic        writeErr;
	logic        writeAccept;

	function automatic logic [31:0] applyStrobes(input logic [31:0] oldVal,
		input logic [31:0] newVal, input logic [3:0] strobes);
		logic [31:0] merged;
		merged = oldVal;
		for (int i = 0; i < 4; i++) begin
			if (strobes[i])
				merged[i*8 +: 8] = newVal[i*8 +: 8];
		end
		return merged;
	endfunction

	assign writeAccept = awvalid && wvalid && !awready && !bvalid;

	// Control writes bounce until start-up is over and while an access runs.
	always_comb begin
		writeErr = 1'b0;
		if (awaddr == regCtrl)
			writeErr = busy || !initDone;
		else if (awaddr != regAddr && awaddr != regWdata && awaddr != regRdata &&
			awaddr != regStatus && awaddr != regMode)
			writeErr = 1'b1;
	end

	always_comb begin
		readErr  = 1'b0;
		readData = '0;
		case (araddr)
			regCtrl:   readData = {29'd0, op, 1'b0};
			regAddr:   readData = {7'd0, accessAddr};
			regWdata:  readData = writeWord;
			regRdata:  readData = readHold;
			regStatus: readData = {30'd0, busy, initDone};
			regMode:   readData = {17'd0, modeWord};
			default:   readErr = 1'b1;
		endcase
	end

	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			bresp      <= respOkay;
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			rdata      <= '0;
			rresp      <= respOkay;
			opStart    <= 1'b0;
			op         <= opWrite;
			accessAddr <= '0;
			writeWord  <= '0;
			modeWord   <= defaultModeWord;
			readHold   <= '0;
		end else begin
			awready <= writeAccept;
			wready  <= writeAccept;
			arready <= arvalid && !arready && !rvalid;
			opStart <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (awready) begin
				bvalid <= 1'b1;
				bresp  <= writeErr ? respSlvErr : respOkay;
				if (!writeErr) begin
					case (awaddr)
						regCtrl: begin
							if (wstrb[0]) begin
								op      <= wdata[2:1];
								opStart <= wdata[0];
							end
						end
						regAddr:  accessAddr <= 25'(applyStrobes({7'd0, accessAddr}, wdata, wstrb));
						regWdata: writeWord <= applyStrobes(writeWord, wdata, wstrb);
						regMode:  modeWord <= 15'(applyStrobes({17'd0, modeWord}, wdata, wstrb));
						default: ;
					endcase
				end
			end
			if (arready) begin
				rvalid <= 1'b1;
				rdata  <= readData;
				rresp  <= readErr ? respSlvErr : respOkay;
			end
			if (readDone)
				readHold <= readWord;
		end
	end

	// A write response is held until the master takes it.
	assert property (@(posedge clk133_270) disable iff (starting)
		bvalid && !bready |=> bvalid);

endmodule

/* verilog/ddrPkg.sv */
package ddrPkg;

	// ============================================================
	// SDRAM commands in {RAS, CAS, WE} bit order.
	// ============================================================
	localparam logic [2:0] cmdLoadMode    = 3'b000;
	localparam logic [2:0] cmdAutoRefresh = 3'b001;
	localparam logic [2:0] cmdPrecharge   = 3'b010;
	localparam logic [2:0] cmdActivate    = 3'b011;
	localparam logic [2:0] cmdWrite       = 3'b100;
	localparam logic [2:0] cmdRead        = 3'b101;
	localparam logic [2:0] cmdNoop        = 3'b111;

	// Datasheet timing in clock cycles.
	localparam int tPowerUp = 26600;
	localparam int tRP      = 3;
	localparam int tMRD     = 2;
	localparam int tRFC     = 11;
	localparam int tRCD     = 3;
	localparam int tWR      = 3;
	localparam int tREFI    = 1040;

	// ============================================================
	// Register map and AXI responses.
	// ============================================================
	localparam logic [7:0] regCtrl   = 8'h00;
	localparam logic [7:0] regAddr   = 8'h04;
	localparam logic [7:0] regWdata  = 8'h08;
	localparam logic [7:0] regRdata  = 8'h0C;
	localparam logic [7:0] regStatus = 8'h10;
	localparam logic [7:0] regMode   = 8'h14;

	localparam logic [1:0] respOkay   = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	localparam logic [1:0] opWrite    = 2'd0;
	localparam logic [1:0] opRead     = 2'd1;
	localparam logic [1:0] opLoadMode = 2'd2;

	// Bank 0 selects the base mode register.
	typedef struct packed {
		logic [1:0] bank;
		logic [5:0] opMode;
		logic [2:0] casLatency;
		logic       burstType;
		logic [2:0] burstLength;
	} baseModeWord;

	// Bank 1 selects the extended mode register.
	typedef struct packed {
		logic [1:0]  bank;
		logic [10:0] reserved;
		logic        driveStrength;
		logic        dllDisable;
	} extModeWord;

	typedef union packed {
		baseModeWord base;
		extModeWord  ext;
	} ddrModeWord;

	// CAS latency 2 and sequential bursts of two.
	localparam ddrModeWord defaultModeWord    = 15'b00_000000_010_0_001;
	// DLL on and full drive strength.
	localparam ddrModeWord defaultExtModeWord = 15'b01_00000000000_0_0;

endpackage
